// ==== bench/periph_soc_checker.sv ====
module periph_soc_checker (
	 input  soc_pkg::data_t                                data_i
	,input  logic                                          rdy_i
	,input  soc_pkg::gpio_t [soc_pkg::GPIO_BANK_COUNT-1:0] gp_i
	,input  logic                                          irq_i
);

	import soc_pkg::*;

	string test_name;
	int    test_errs   = 0;
	int    test_checks = 0;
	int    test_cnt    = 0;
	int    fail_cnt    = 0;
	int    err_cnt     = 0;

	task automatic report_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		test_checks++;
		if (exp !== act) begin
			test_errs++;
			err_cnt++;
			$display("error %s: %s expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
		end
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errs   = 0;
		test_checks = 0;
	endtask

	// Ports are sampled at the falling edge, where they are stable
	task automatic data_equals(input data_t exp);
		report_value("data_o", exp, data_i);
	endtask

	task automatic pins_equal(input gpio_t [GPIO_BANK_COUNT-1:0] exp);
		report_value("gp_o", 32'(exp), 32'(gp_i));
	endtask

	task automatic irq_equals(input logic exp);
		report_value("irq_o", 32'(exp), 32'(irq_i));
	endtask

	task automatic rdy_equals(input logic exp);
		report_value("rdy_o", 32'(exp), 32'(rdy_i));
	endtask

	task automatic require(input logic ok, input string msg);
		test_checks++;
		if (!ok) begin
			test_errs++;
			err_cnt++;
			$display("%s: %s", test_name, msg);
		end
	endtask

	task automatic close_test();
		test_cnt++;
		if (test_errs != 0) begin
			fail_cnt++;
			$display("test %s: failed, %0d of %0d checks wrong", test_name, test_errs, test_checks);
		end else begin
			$display("test %s: passed, %0d checks", test_name, test_checks);
		end
	endtask

endmodule

// ==== bench/periph_soc_tb.sv ====
module periph_soc_tb;

	import soc_pkg::*;

	// Five short tests need well under a thousand cycles
	localparam int CYCLE_LIMIT = 4000;
	localparam int OUT_RUNS    = 16;
	localparam int IRQ_RUNS    = 8;
	localparam int BAD_RUNS    = 10;

	logic                        clk200mhz_w;
	logic                        rst_p;
	logic                        rst_req_r;
	pi1_op_t                     op_r;
	addr_t                       addr_r;
	data_t                       data_r;
	sel_t                        sel_r;
	data_t                       data_w;
	logic                        rdy_w;
	logic                        irq_w;
	gpio_t [GPIO_BANK_COUNT-1:0] gp_in_r;
	gpio_t [GPIO_BANK_COUNT-1:0] gp_out_w;

	// Model of the GPIO output and pending registers
	gpio_t [GPIO_BANK_COUNT-1:0] out_m;
	gpio_t [GPIO_BANK_COUNT-1:0] pend_m;
	logic [31:0]                 rng_state;
	int                          cycle_cnt = 0;

	tb_clock clock_i (
		 .rst_req_i (rst_req_r)
		,.clk_o     (clk200mhz_w)
		,.rst_o     (rst_p)
	);

	periph_soc dut_i (
		 .clk200mhz_w (clk200mhz_w)
		,.rst_p       (rst_p)
		,.op_i        (op_r)
		,.addr_i      (addr_r)
		,.data_i      (data_r)
		,.sel_i       (sel_r)
		,.data_o      (data_w)
		,.rdy_o       (rdy_w)
		,.gp_i        (gp_in_r)
		,.gp_o        (gp_out_w)
		,.irq_o       (irq_w)
	);

	periph_soc_checker checker_i (
		 .data_i (data_w)
		,.rdy_i  (rdy_w)
		,.gp_i   (gp_out_w)
		,.irq_i  (irq_w)
	);

	function automatic logic [31:0] xorshift32();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic slot_t bank_slot(input int b);
		return slot_t'(int'(SLOT_GPIO0) + b);
	endfunction

	// Table words: id, slot count, then one entry per populated slot
	function automatic data_t table_word(input int idx);
		data_t entry;
		int    s;
		s = idx - 2;
		if (idx == 0)
			return SOC_ID;
		if (idx == 1)
			return data_t'(SLOT_COUNT);
		if (s >= 0 && s < int'(SLOT_COUNT)) begin
			entry = data_t'(MAPSZ_WORDS) << 16;
			if (s == int'(SLOT_DEVTBL))
				entry |= data_t'(DEV_ID_DEVTBL);
			else
				entry |= 32'h8000 | data_t'(DEV_ID_GPIO);
			return entry;
		end
		return '0;
	endfunction

	// Holds the request until an edge with rdy_o high, returns at the next falling edge
	task automatic transfer(input pi1_op_t op, input addr_t addr, input data_t wdata, input sel_t sel);
		logic accepted;
		@(posedge clk200mhz_w);
		op_r     <= op;
		addr_r   <= addr;
		data_r   <= wdata;
		sel_r    <= sel;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk200mhz_w);
			accepted = rdy_w;
			@(posedge clk200mhz_w);
		end
		op_r <= OP_NONE;
		@(negedge clk200mhz_w);
	endtask

	task automatic write_word(input slot_t slot, input reg_idx_t idx, input data_t d);
		transfer(OP_WR, {slot, idx}, d, 4'hf);
	endtask

	task automatic read_expect(input slot_t slot, input reg_idx_t idx, input data_t exp);
		transfer(OP_RD, {slot, idx}, '0, 4'hf);
		checker_i.data_equals(exp);
	endtask

	task automatic wait_rdy(input logic level, output int cycles);
		cycles = 0;
		while (rdy_w != level) begin
			@(negedge clk200mhz_w);
			cycles++;
		end
	endtask

	task automatic devtbl_test();
		checker_i.start_test("device table");
		for (int i = 0; i < 6; i++)
			read_expect(SLOT_DEVTBL, reg_idx_t'(i), table_word(i));
		checker_i.close_test();
	endtask

	task automatic gpio_out_test();
		int      b;
		data_t   d;
		sel_t    s;
		pi1_op_t op;
		gpio_t   old;
		checker_i.start_test("gpio output");
		repeat (OUT_RUNS) begin
			b   = int'(xorshift32() % GPIO_BANK_COUNT);
			d   = xorshift32();
			s   = sel_t'(xorshift32());
			op  = ((xorshift32() & 32'd1) != 0) ? OP_RDWR : OP_WR;
			old = out_m[b];
			transfer(op, {bank_slot(b), GPIO_REG_OUT}, d, s);
			// Read-write hands back the value from before the write
			if (op == OP_RDWR)
				checker_i.data_equals(data_t'(old));
			if (s[0])
				out_m[b] = d[GPIO_WIDTH-1:0];
			read_expect(bank_slot(b), GPIO_REG_OUT, data_t'(out_m[b]));
			checker_i.pins_equal(out_m);
		end
		checker_i.close_test();
	endtask

	task automatic gpio_irq_test();
		int    b;
		gpio_t m;
		gpio_t v;
		gpio_t c;
		checker_i.start_test("gpio input and interrupt");
		repeat (IRQ_RUNS) begin
			b = int'(xorshift32() % GPIO_BANK_COUNT);
			m = gpio_t'(xorshift32());
			v = gpio_t'(xorshift32());
			c = gpio_t'(xorshift32());
			write_word(bank_slot(b), GPIO_REG_MASK, data_t'(m));
			@(posedge clk200mhz_w);
			pend_m[b] = (v ^ gp_in_r[b]) & m;
			gp_in_r[b] <= v;
			// Two synchronizer flops, one edge detect, one pending update
			repeat (4) @(posedge clk200mhz_w);
			@(negedge clk200mhz_w);
			read_expect(bank_slot(b), GPIO_REG_IN, data_t'(v));
			read_expect(bank_slot(b), GPIO_REG_PEND, data_t'(pend_m[b]));
			checker_i.irq_equals(|pend_m);
			write_word(bank_slot(b), GPIO_REG_PEND, data_t'(c));
			pend_m[b] &= ~c;
			read_expect(bank_slot(b), GPIO_REG_PEND, data_t'(pend_m[b]));
			checker_i.irq_equals(|pend_m);
			write_word(bank_slot(b), GPIO_REG_PEND, 32'hff);
			pend_m[b] = '0;
			checker_i.irq_equals(|pend_m);
		end
		checker_i.close_test();
	endtask

	task automatic invalid_slot_test();
		slot_t   bad;
		pi1_op_t op;
		checker_i.start_test("invalid slots");
		repeat (BAD_RUNS) begin
			bad = slot_t'(xorshift32());
			if (bad < SLOT_COUNT)
				bad = bad + SLOT_COUNT;
			op = pi1_op_t'(2'(1 + xorshift32() % 3));
			transfer(op, {bad, reg_idx_t'(xorshift32())}, xorshift32(), 4'hf);
			checker_i.data_equals('0);
			// A stray reset request would drop rdy_o one edge after acceptance
			@(negedge clk200mhz_w);
			checker_i.rdy_equals(1'b1);
		end
		for (int b = 0; b < GPIO_BANK_COUNT; b++)
			read_expect(bank_slot(b), GPIO_REG_OUT, data_t'(out_m[b]));
		checker_i.pins_equal(out_m);
		checker_i.close_test();
	endtask

	task automatic reset_ctrl_test();
		data_t d;
		int    n;
		checker_i.start_test("reset control");
		for (int b = 0; b < GPIO_BANK_COUNT; b++) begin
			d = xorshift32() | 32'h1;
			write_word(bank_slot(b), GPIO_REG_OUT, d);
			write_word(bank_slot(b), GPIO_REG_MASK, d);
			out_m[b] = d[GPIO_WIDTH-1:0];
		end
		checker_i.pins_equal(out_m);
		// Warm reset, bit 1 set
		d    = xorshift32();
		d[1] = 1'b1;
		write_word(SLOT_DEVTBL, DEVTBL_REG_RST, d);
		wait_rdy(1'b0, n);
		checker_i.require(n <= 2, "rdy_o did not fall after the warm-reset write");
		wait_rdy(1'b1, n);
		checker_i.require(n <= RST_HOLD_CYCLES + 2, "rdy_o did not return within the hold time");
		out_m  = '0;
		pend_m = '0;
		checker_i.pins_equal(out_m);
		for (int b = 0; b < GPIO_BANK_COUNT; b++) begin
			read_expect(bank_slot(b), GPIO_REG_OUT, '0);
			read_expect(bank_slot(b), GPIO_REG_MASK, '0);
			read_expect(bank_slot(b), GPIO_REG_PEND, '0);
		end
		// Power-off, bits 1:0 equal to 01
		d      = xorshift32();
		d[1:0] = 2'b01;
		write_word(SLOT_DEVTBL, DEVTBL_REG_RST, d);
		wait_rdy(1'b0, n);
		checker_i.require(n <= 2, "rdy_o did not fall after the power-off write");
		repeat (3 * RST_HOLD_CYCLES) begin
			@(negedge clk200mhz_w);
			checker_i.rdy_equals(1'b0);
		end
		@(posedge clk200mhz_w);
		rst_req_r <= 1'b1;
		repeat (3) @(posedge clk200mhz_w);
		rst_req_r <= 1'b0;
		@(negedge clk200mhz_w);
		wait_rdy(1'b1, n);
		checker_i.require(n <= RST_HOLD_CYCLES + 2, "rdy_o did not return after the external reset");
		checker_i.pins_equal(out_m);
		checker_i.irq_equals(1'b0);
		read_expect(SLOT_DEVTBL, DEVTBL_REG_SOC_ID, SOC_ID);
		checker_i.close_test();
	endtask

	always @(posedge clk200mhz_w) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		op_r      <= OP_NONE;
		addr_r    <= '0;
		data_r    <= '0;
		sel_r     <= '0;
		gp_in_r   <= '0;
		rst_req_r <= 1'b0;
		rng_state = 32'hd5be_2d39;
		out_m     = '0;
		pend_m    = '0;
		@(negedge clk200mhz_w);
		devtbl_test();
		gpio_out_test();
		gpio_irq_test();
		invalid_slot_test();
		reset_ctrl_test();
		$display("tests %0d, failed %0d, check errors %0d, cycles %0d",
			checker_i.test_cnt, checker_i.fail_cnt, checker_i.err_cnt, cycle_cnt);
		if (checker_i.err_cnt == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== bench/tb_clock.sv ====
module tb_clock (
	 input  logic rst_req_i
	,output logic clk_o
	,output logic rst_o
);

	logic init_rst_r;

	initial begin
		clk_o = 1'b0;
		forever #50 clk_o = ~clk_o;
	end

	// Power-on reset covers the first three rising edges
	initial begin
		init_rst_r <= 1'b1;
		repeat (3) @(posedge clk_o);
		init_rst_r <= 1'b0;
	end

	assign rst_o = init_rst_r | rst_req_i;

endmodule

// ==== logic/dev_table.sv ====
module dev_table (
	 input  logic  clk200mhz_w
	,input  logic  sys_rst_i
	,pi1_if.slave  bus
	,output logic  warm_req_o
	,output logic  off_req_o
);

	import soc_pkg::*;

	logic  accept_w;
	logic  rd_w;
	logic  wr_w;
	slot_t entry_slot_w;
	data_t rd_value_w;
	data_t rdata_r;

	// Map size, interrupt flag and device id of one slot
	function automatic data_t dev_entry(input slot_t s);
		logic        useintr;
		logic [14:0] id;
		useintr = (s != SLOT_DEVTBL);
		id      = (s == SLOT_DEVTBL) ? 15'(DEV_ID_DEVTBL) : 15'(DEV_ID_GPIO);
		return {16'(MAPSZ_WORDS), useintr, id};
	endfunction

	assign bus.rdy  = !sys_rst_i;
	assign accept_w = (bus.op != OP_NONE) && bus.rdy;
	assign rd_w     = accept_w && ((bus.op == OP_RD) || (bus.op == OP_RDWR));
	assign wr_w     = accept_w && ((bus.op == OP_WR) || (bus.op == OP_RDWR));

	assign entry_slot_w = slot_t'(bus.addr) - slot_t'(DEVTBL_REG_ENTRY0);

	always_comb begin
		rd_value_w = '0;
		if (bus.addr == DEVTBL_REG_SOC_ID)
			rd_value_w = SOC_ID;
		else if (bus.addr == DEVTBL_REG_SLOTS)
			rd_value_w = data_t'(SLOT_COUNT);
		else if ((bus.addr >= DEVTBL_REG_ENTRY0) && (entry_slot_w < SLOT_COUNT))
			rd_value_w = dev_entry(entry_slot_w);
	end

	always_ff @(posedge clk200mhz_w) begin
		rdata_r <= rd_w ? rd_value_w : '0;
	end

	assign bus.rdata = rdata_r;

	// Bit 1 requests a warm reset, 01 alone powers off
	always_ff @(posedge clk200mhz_w) begin
		if (sys_rst_i) begin
			warm_req_o <= 1'b0;
			off_req_o  <= 1'b0;
		end else begin
			warm_req_o <= wr_w && (bus.addr == DEVTBL_REG_RST) && bus.wdata[1];
			off_req_o  <= wr_w && (bus.addr == DEVTBL_REG_RST) && (bus.wdata[1:0] == 2'b01);
		end
	end

endmodule

// ==== logic/gpio_bank.sv ====
module gpio_bank (
	 input  logic            clk200mhz_w
	,input  logic            sys_rst_i
	,pi1_if.slave            bus
	,input  soc_pkg::gpio_t  pin_i
	,output soc_pkg::gpio_t  pin_o
	,output logic            intrqst_o
);

	import soc_pkg::*;

	logic  accept_w;
	logic  rd_w;
	logic  wr_w;
	gpio_t out_r;
	gpio_t mask_r;
	gpio_t pend_r;
	gpio_t sync1_r;
	gpio_t sync2_r;
	gpio_t prev_r;
	gpio_t change_w;
	gpio_t clr_w;
	data_t rd_value_w;
	data_t rdata_r;

	assign bus.rdy  = !sys_rst_i;
	assign accept_w = (bus.op != OP_NONE) && bus.rdy;
	assign rd_w     = accept_w && ((bus.op == OP_RD) || (bus.op == OP_RDWR));
	assign wr_w     = accept_w && ((bus.op == OP_WR) || (bus.op == OP_RDWR));

	// Two-flop input synchronizer, plus the previous synced value
	always_ff @(posedge clk200mhz_w) begin
		sync1_r <= pin_i;
		sync2_r <= sync1_r;
		prev_r  <= sync2_r;
	end

	assign change_w = sync2_r ^ prev_r;
	assign clr_w    = (wr_w && (bus.addr == GPIO_REG_PEND)) ? bus.wdata[GPIO_WIDTH-1:0] : '0;

	always_ff @(posedge clk200mhz_w) begin
		if (sys_rst_i) begin
			out_r  <= '0;
			mask_r <= '0;
			pend_r <= '0;
		end else begin
			if (wr_w && (bus.addr == GPIO_REG_OUT) && bus.sel[0])
				out_r <= bus.wdata[GPIO_WIDTH-1:0];
			if (wr_w && (bus.addr == GPIO_REG_MASK))
				mask_r <= bus.wdata[GPIO_WIDTH-1:0];
			// New changes win over a write-one-to-clear in the same cycle
			pend_r <= (pend_r & ~clr_w) | (change_w & mask_r);
		end
	end

	always_comb begin
		case (bus.addr)
			GPIO_REG_OUT:  rd_value_w = data_t'(out_r);
			GPIO_REG_IN:   rd_value_w = data_t'(sync2_r);
			GPIO_REG_MASK: rd_value_w = data_t'(mask_r);
			GPIO_REG_PEND: rd_value_w = data_t'(pend_r);
			default:       rd_value_w = '0;
		endcase
	end

	// Read data is the value before any write at the same edge
	always_ff @(posedge clk200mhz_w) begin
		rdata_r <= rd_w ? rd_value_w : '0;
	end

	assign bus.rdata = rdata_r;
	assign pin_o     = out_r;
	assign intrqst_o = |pend_r;

endmodule

// ==== logic/periph_soc.sv ====
module periph_soc (
	 input  logic                                        clk200mhz_w
	,input  logic                                        rst_p
	,input  soc_pkg::pi1_op_t                            op_i
	,input  soc_pkg::addr_t                              addr_i
	,input  soc_pkg::data_t                              data_i
	,input  soc_pkg::sel_t                               sel_i
	,output soc_pkg::data_t                              data_o
	,output logic                                        rdy_o
	,input  soc_pkg::gpio_t [soc_pkg::GPIO_BANK_COUNT-1:0] gp_i
	,output soc_pkg::gpio_t [soc_pkg::GPIO_BANK_COUNT-1:0] gp_o
	,output logic                                        irq_o
);

	import soc_pkg::*;

	logic                       sys_rst_w;
	logic                       warm_req_w;
	logic                       off_req_w;
	slot_t                      resp_slot_w;
	logic [GPIO_BANK_COUNT-1:0] intrqst_w;

	pi1_if devtbl_bus ();
	pi1_if gpio_bus [GPIO_BANK_COUNT] ();

	rst_sequencer rst_sequencer (
		 .clk200mhz_w (clk200mhz_w)
		,.rst_p       (rst_p)
		,.warm_req_i  (warm_req_w)
		,.off_req_i   (off_req_w)
		,.sys_rst_o   (sys_rst_w)
	);

	pi1_decoder pi1_decoder (
		 .clk200mhz_w (clk200mhz_w)
		,.sys_rst_i   (sys_rst_w)
		,.op_i        (op_i)
		,.addr_i      (addr_i)
		,.data_i      (data_i)
		,.sel_i       (sel_i)
		,.rdy_o       (rdy_o)
		,.devtbl      (devtbl_bus)
		,.gpio        (gpio_bus)
		,.resp_slot_o (resp_slot_w)
	);

	dev_table dev_table (
		 .clk200mhz_w (clk200mhz_w)
		,.sys_rst_i   (sys_rst_w)
		,.bus         (devtbl_bus)
		,.warm_req_o  (warm_req_w)
		,.off_req_o   (off_req_w)
	);

	// Bank b sits in slot SLOT_GPIO0+b and drives pins b of gp_o
	generate
		for (genvar b = 0; b < GPIO_BANK_COUNT; b++) begin : g_bank
			gpio_bank gpio_bank (
				 .clk200mhz_w (clk200mhz_w)
				,.sys_rst_i   (sys_rst_w)
				,.bus         (gpio_bus[b])
				,.pin_i       (gp_i[b])
				,.pin_o       (gp_o[b])
				,.intrqst_o   (intrqst_w[b])
			);
		end
	endgenerate

	pi1_resp_mux pi1_resp_mux (
		 .resp_slot_i (resp_slot_w)
		,.devtbl      (devtbl_bus)
		,.gpio        (gpio_bus)
		,.intrqst_i   (intrqst_w)
		,.data_o      (data_o)
		,.irq_o       (irq_o)
	);

endmodule

// ==== logic/pi1_decoder.sv ====
module pi1_decoder (
	 input  logic               clk200mhz_w
	,input  logic               sys_rst_i
	,input  soc_pkg::pi1_op_t   op_i
	,input  soc_pkg::addr_t     addr_i
	,input  soc_pkg::data_t     data_i
	,input  soc_pkg::sel_t      sel_i
	,output logic               rdy_o
	,pi1_if.master              devtbl
	,pi1_if.master              gpio [soc_pkg::GPIO_BANK_COUNT]
	,output soc_pkg::slot_t     resp_slot_o
);

	import soc_pkg::*;

	slot_t                      slot_w;
	reg_idx_t                   idx_w;
	logic [GPIO_BANK_COUNT-1:0] gpio_rdy_w;
	logic                       sel_rdy_w;
	logic                       accept_w;

	assign slot_w = addr_i[$bits(addr_t)-1 -: $bits(slot_t)];
	assign idx_w  = addr_i[$bits(reg_idx_t)-1:0];

	// Only the addressed link sees an operation
	assign devtbl.op    = (slot_w == SLOT_DEVTBL) ? op_i : OP_NONE;
	assign devtbl.addr  = idx_w;
	assign devtbl.wdata = data_i;
	assign devtbl.sel   = sel_i;

	generate
		for (genvar b = 0; b < GPIO_BANK_COUNT; b++) begin : g_gpio
			assign gpio[b].op    = (slot_w == slot_t'(SLOT_GPIO0 + b)) ? op_i : OP_NONE;
			assign gpio[b].addr  = idx_w;
			assign gpio[b].wdata = data_i;
			assign gpio[b].sel   = sel_i;
			assign gpio_rdy_w[b] = gpio[b].rdy;
		end
	endgenerate

	// Invalid-device default is always ready
	always_comb begin
		sel_rdy_w = 1'b1;
		if (slot_w == SLOT_DEVTBL)
			sel_rdy_w = devtbl.rdy;
		for (int b = 0; b < GPIO_BANK_COUNT; b++) begin
			if (slot_w == slot_t'(SLOT_GPIO0 + b))
				sel_rdy_w = gpio_rdy_w[b];
		end
	end

	assign rdy_o    = !sys_rst_i && sel_rdy_w;
	assign accept_w = (op_i != OP_NONE) && rdy_o;

	// SLOT_COUNT marks no response or an unpopulated slot
	always_ff @(posedge clk200mhz_w) begin
		if (sys_rst_i || !accept_w)
			resp_slot_o <= SLOT_COUNT;
		else
			resp_slot_o <= (slot_w < SLOT_COUNT) ? slot_w : SLOT_COUNT;
	end

endmodule

// ==== logic/pi1_if.sv ====
interface pi1_if;

	import soc_pkg::*;

	// Request side, driven by the decoder
	pi1_op_t  op;
	reg_idx_t addr;
	data_t    wdata;
	sel_t     sel;

	// Response side, driven by the slave
	data_t rdata;
	logic  rdy;

	modport master (output op, addr, wdata, sel, input rdata, rdy);

	modport slave (input op, addr, wdata, sel, output rdata, rdy);

	// Read data tap for the response collector
	modport monitor (input rdata);

endinterface

// ==== logic/pi1_resp_mux.sv ====
module pi1_resp_mux (
	 input  soc_pkg::slot_t                      resp_slot_i
	,pi1_if.monitor                              devtbl
	,pi1_if.monitor                              gpio [soc_pkg::GPIO_BANK_COUNT]
	,input  logic [soc_pkg::GPIO_BANK_COUNT-1:0] intrqst_i
	,output soc_pkg::data_t                      data_o
	,output logic                                irq_o
);

	import soc_pkg::*;

	data_t gpio_rdata_w [GPIO_BANK_COUNT];

	generate
		for (genvar b = 0; b < GPIO_BANK_COUNT; b++) begin : g_tap
			assign gpio_rdata_w[b] = gpio[b].rdata;
		end
	endgenerate

	// Unpopulated slots and idle cycles return zero
	always_comb begin
		data_o = '0;
		if (resp_slot_i == SLOT_DEVTBL)
			data_o = devtbl.rdata;
		for (int b = 0; b < GPIO_BANK_COUNT; b++) begin
			if (resp_slot_i == slot_t'(SLOT_GPIO0 + b))
				data_o = gpio_rdata_w[b];
		end
	end

	// Single request line in place of an interrupt controller
	assign irq_o = |intrqst_i;

endmodule

// ==== logic/rst_sequencer.sv ====
module rst_sequencer (
	 input  logic clk200mhz_w
	,input  logic rst_p
	,input  logic warm_req_i
	,input  logic off_req_i
	,output logic sys_rst_o
);

	import soc_pkg::*;

	rst_state_t state_r;
	rst_cntr_t  cntr_r;

	always_ff @(posedge clk200mhz_w) begin
		if (rst_p) begin
			state_r <= RST_HOLD;
			cntr_r  <= rst_cntr_t'(RST_HOLD_CYCLES);
		end else begin
			case (state_r)
				RST_HOLD: begin
					// Release on the last count of the hold window
					if (cntr_r == rst_cntr_t'(1))
						state_r <= RST_RUN;
					else
						cntr_r <= cntr_r - rst_cntr_t'(1);
				end
				RST_RUN: begin
					if (off_req_i) begin
						state_r <= RST_OFF;
					end else if (warm_req_i) begin
						state_r <= RST_HOLD;
						cntr_r  <= rst_cntr_t'(RST_HOLD_CYCLES);
					end
				end
				RST_OFF: begin
					// Powered off, only the external reset brings it back
					state_r <= RST_OFF;
				end
				default: begin
					state_r <= RST_HOLD;
					cntr_r  <= rst_cntr_t'(RST_HOLD_CYCLES);
				end
			endcase
		end
	end

	assign sys_rst_o = (state_r != RST_RUN);

endmodule

// ==== logic/soc_pkg.sv ====
package soc_pkg;

	// Bus word, byte enables and word address
	typedef logic [31:0] data_t;
	typedef logic [3:0]  sel_t;
	typedef logic [11:0] addr_t;

	// Low address bits pick a register, high bits pick a slot
	typedef logic [3:0] reg_idx_t;
	typedef logic [7:0] slot_t;

	localparam int GPIO_WIDTH = 8;
	typedef logic [GPIO_WIDTH-1:0] gpio_t;

	// PI1 operations, RDWR writes and hands back the previous value
	typedef enum logic [1:0] {
		OP_NONE = 2'd0,
		OP_WR   = 2'd1,
		OP_RD   = 2'd2,
		OP_RDWR = 2'd3
	} pi1_op_t;

	// Slot map, every slot spans the same number of words
	localparam int    MAPSZ_WORDS     = 16;
	localparam int    GPIO_BANK_COUNT = 2;
	localparam slot_t SLOT_DEVTBL     = 8'd0;
	localparam slot_t SLOT_GPIO0      = 8'd1;
	localparam slot_t SLOT_COUNT      = 8'd3;

	// Device table contents
	localparam data_t SOC_ID        = 32'd4;
	localparam int    DEV_ID_DEVTBL = 7;
	localparam int    DEV_ID_GPIO   = 6;

	// Device table register words
	localparam reg_idx_t DEVTBL_REG_SOC_ID = 4'd0;
	localparam reg_idx_t DEVTBL_REG_SLOTS  = 4'd1;
	localparam reg_idx_t DEVTBL_REG_ENTRY0 = 4'd2;
	localparam reg_idx_t DEVTBL_REG_RST    = 4'd15;

	// GPIO bank register words
	localparam reg_idx_t GPIO_REG_OUT  = 4'd0;
	localparam reg_idx_t GPIO_REG_IN   = 4'd1;
	localparam reg_idx_t GPIO_REG_MASK = 4'd2;
	localparam reg_idx_t GPIO_REG_PEND = 4'd3;

	// Reset sequencing
	localparam int RST_HOLD_CYCLES = 16;
	typedef logic [4:0] rst_cntr_t;

	typedef enum logic [1:0] {
		RST_HOLD,
		RST_RUN,
		RST_OFF
	} rst_state_t;

endpackage

// ==== periph_soc.f ====
logic/soc_pkg.sv
logic/pi1_if.sv
logic/rst_sequencer.sv
logic/pi1_decoder.sv
logic/dev_table.sv
logic/gpio_bank.sv
logic/pi1_resp_mux.sv
logic/periph_soc.sv
bench/tb_clock.sv
bench/periph_soc_checker.sv
bench/periph_soc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module periph_soc_tb -f periph_soc.f -o periph_soc_sim

out=$(./obj_dir/periph_soc_sim)
echo "$out"

# Exit status comes from the search for the pass line
echo "$out" | grep -qx "Test OK"
